//--- include/rv_decode_macros.svh
// ----------------------------------------
// Configuration macros for the RV32 decode stage
// Data and register index widths, reset vector, PC step
// and the extension enables
// ----------------------------------------

`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// Data and address width
`define RV_XLEN 32

// Register index width, 32 integer registers
`define RV_REGADDR_W 5

// First instruction fetched after reset
`define RV_RESET_VECTOR 32'h0000_0040

// Every instruction is 32 bits wide, so the PC always steps by 4
`define RV_INSTR_STEP 4

// Extension enables, 1 to decode and 0 to treat as illegal
`define RV_HAVE_M 1
`define RV_HAVE_CSR 1

`endif

//--- hw/rv_decode_pkg.sv
// ----------------------------------------
// Decode stage package
// Instruction format views as a packed union
// Execute control enums
// ----------------------------------------

package rv_decode_pkg;

	// ----------------------------------------
	// Instruction formats

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// B-type shares this layout, only the immediate bits are shuffled
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// J-type shares this layout
	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		u_fmt_t u;
	} instr_u;

	// ----------------------------------------
	// Execute controls

	typedef enum logic [3:0] {
		ALUOP_ADD, ALUOP_SUB, ALUOP_LT, ALUOP_LTU, ALUOP_XOR, ALUOP_OR,
		ALUOP_AND, ALUOP_SLL, ALUOP_SRL, ALUOP_SRA, ALUOP_MULDIV
	} aluop_e;

	typedef enum logic {ALUSRCA_RS1, ALUSRCA_PC} alusrc_a_e;
	typedef enum logic {ALUSRCB_RS2, ALUSRCB_IMM} alusrc_b_e;

	typedef enum logic [3:0] {
		MEMOP_NONE, MEMOP_LB, MEMOP_LH, MEMOP_LW, MEMOP_LBU,
		MEMOP_LHU, MEMOP_SB, MEMOP_SH, MEMOP_SW
	} memop_e;

	// Order matches funct3 of the M extension
	typedef enum logic [2:0] {
		M_OP_MUL, M_OP_MULH, M_OP_MULHSU, M_OP_MULHU,
		M_OP_DIV, M_OP_DIVU, M_OP_REM, M_OP_REMU
	} mulop_e;

	typedef enum logic [1:0] {BCOND_NEVER, BCOND_ZERO, BCOND_NZERO, BCOND_ALWAYS} bcond_e;
	typedef enum logic [1:0] {CSR_WTYPE_W, CSR_WTYPE_S, CSR_WTYPE_C} csr_wtype_e;

	typedef enum logic [2:0] {
		EXCEPT_NONE, EXCEPT_ECALL, EXCEPT_EBREAK, EXCEPT_MRET,
		EXCEPT_INSTR_FAULT, EXCEPT_INSTR_ILLEGAL
	} except_e;

endpackage

//--- hw/rv_imm_if.sv
// ----------------------------------------
// Immediate bundle between the immediate
// generator and the instruction decoder
// ----------------------------------------

`include "rv_decode_macros.svh"

interface rv_imm_if;

	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;

	modport producer (output imm_i, imm_s, imm_b, imm_u, imm_j);

	// The J immediate only feeds the jump offset inside the generator
	modport consumer (input imm_i, imm_s, imm_b, imm_u);

endinterface

//--- hw/rv_imm_gen.sv
// ----------------------------------------
// Immediate generator
// Builds the I, S, B, U and J immediates and
// picks the jump offset for the fetch side
// ----------------------------------------

`include "rv_decode_macros.svh"

module rv_imm_gen (
	input  rv_decode_pkg::instr_u  instr_i,
	rv_imm_if.producer             imm,
	output logic [`RV_XLEN-1:0]    jump_offs_o
);
	import rv_decode_pkg::*;

	// Bit 31 of the word is the sign bit in every format
	assign imm.imm_i = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
	assign imm.imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
	assign imm.imm_u = {instr_i.u.imm20, 12'h000};

	// B and J scatter their offset bits, bit 0 is always zero
	assign imm.imm_b = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_lo[0],
		instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
	assign imm.imm_j = {{12{instr_i.u.imm20[19]}}, instr_i.u.imm20[7:0],
		instr_i.u.imm20[8], instr_i.u.imm20[18:9], 1'b0};

	// JAL 1101111, JALR 1100111, branches 1100011
	always_comb begin
		casez (instr_i.u.opcode[3:2])
			2'b1?:   jump_offs_o = imm.imm_j;
			2'b01:   jump_offs_o = imm.imm_i;
			default: jump_offs_o = imm.imm_b;
		endcase
	end

endmodule

//--- hw/rv_pc_ctrl.sv
// ----------------------------------------
// PC and CIR control
// Program counter register, starvation and bus
// fault flags, buffer use and the CIR lock
// ----------------------------------------

`include "rv_decode_macros.svh"

module rv_pc_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cir_vld_i,
	input  logic                cir_err_i,
	input  logic                x_stall_i,
	input  logic                jump_now_i,
	input  logic [`RV_XLEN-1:0] jump_target_i,
	input  logic                jump_not_except_i,
	output logic                cir_use_o,
	output logic                cir_lock_o,
	output logic                starved_o,
	output logic                bus_fault_o,
	output logic                lock_prev_o,
	output logic [`RV_XLEN-1:0] pc_o
);

	localparam logic [`RV_XLEN-1:0] PC_STEP = `RV_INSTR_STEP;

	logic d_stall;
	logic assert_lock;
	logic jump_load;

	assign starved_o   = !cir_vld_i;
	assign bus_fault_o = cir_vld_i && cir_err_i;
	assign d_stall     = x_stall_i || starved_o;
	assign cir_use_o   = !d_stall;

	// ----------------------------------------
	// CIR lock

	// A jump accepted while decode is held must keep its word in the CIR,
	// otherwise fetch overwrites it and the link or recovery is lost
	assign assert_lock = jump_now_i && jump_not_except_i && d_stall;
	assign cir_lock_o  = (lock_prev_o && d_stall) || assert_lock;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_prev_o <= 1'b0;
		end else begin
			lock_prev_o <= cir_lock_o;
		end
	end

	// ----------------------------------------
	// Program counter

	// The target is loaded either right away or at the edge where a lock releases
	assign jump_load = (jump_now_i && !assert_lock) || (lock_prev_o && !d_stall);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_o <= `RV_RESET_VECTOR;
		end else if (jump_load) begin
			pc_o <= jump_target_i;
		end else if (!d_stall && !cir_lock_o) begin
			pc_o <= pc_o + PC_STEP;
		end
	end

	// ----------------------------------------
	// Assertions

	a_use_needs_valid: assert property (
		@(posedge clk) disable iff (!rst_n) cir_use_o |-> cir_vld_i);

	a_use_not_stalled: assert property (
		@(posedge clk) disable iff (!rst_n) cir_use_o |-> !x_stall_i);

	// A locked word keeps its PC until the lock is released
	a_lock_holds_pc: assert property (
		@(posedge clk) disable iff (!rst_n) cir_lock_o |=> $stable(pc_o));

endmodule

//--- hw/rv_instr_decoder.sv
// ----------------------------------------
// Instruction decoder
// Turns the CIR word into execute controls for
// RV32I, M and the CSR/system group, then
// squashes illegal, starved and faulted words
// ----------------------------------------

`include "rv_decode_macros.svh"

module rv_instr_decoder (
	input  rv_decode_pkg::instr_u       instr_i,
	rv_imm_if.consumer                  imm,
	input  logic                        starved_i,
	input  logic                        bus_fault_i,
	input  logic                        lock_prev_i,
	output logic [`RV_XLEN-1:0]         imm_o,
	output logic [`RV_REGADDR_W-1:0]    rs1_o,
	output logic [`RV_REGADDR_W-1:0]    rs2_o,
	output logic [`RV_REGADDR_W-1:0]    rd_o,
	output rv_decode_pkg::alusrc_a_e    alusrc_a_o,
	output rv_decode_pkg::alusrc_b_e    alusrc_b_o,
	output rv_decode_pkg::aluop_e       aluop_o,
	output rv_decode_pkg::memop_e       memop_o,
	output rv_decode_pkg::mulop_e       mulop_o,
	output logic                        csr_ren_o,
	output logic                        csr_wen_o,
	output rv_decode_pkg::csr_wtype_e   csr_wtype_o,
	output logic                        csr_w_imm_o,
	output rv_decode_pkg::bcond_e       branchcond_o,
	output logic                        jump_is_regoffs_o,
	output rv_decode_pkg::except_e      except_o,
	output logic                        wfi_o
);
	import rv_decode_pkg::*;

	localparam logic [`RV_REGADDR_W-1:0] X0 = '0;
	localparam logic [`RV_XLEN-1:0] LINK_STEP = `RV_INSTR_STEP;

	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       f7_zero;
	logic       f7_alt;
	logic       invalid;

	assign opcode  = instr_i.r.opcode;
	assign funct3  = instr_i.r.funct3;
	assign funct7  = instr_i.r.funct7;
	assign f7_zero = funct7 == 7'b0000000;
	assign f7_alt  = funct7 == 7'b0100000;

	// Shared ALU mapping of OP and OP-IMM, alt selects SUB and SRA
	function automatic aluop_e f3_aluop(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  f3_aluop = alt ? ALUOP_SUB : ALUOP_ADD;
			3'b001:  f3_aluop = ALUOP_SLL;
			3'b010:  f3_aluop = ALUOP_LT;
			3'b011:  f3_aluop = ALUOP_LTU;
			3'b100:  f3_aluop = ALUOP_XOR;
			3'b101:  f3_aluop = alt ? ALUOP_SRA : ALUOP_SRL;
			3'b110:  f3_aluop = ALUOP_OR;
			default: f3_aluop = ALUOP_AND;
		endcase
	endfunction

	always_comb begin
		rs1_o             = instr_i.r.rs1;
		rs2_o             = instr_i.r.rs2;
		rd_o              = instr_i.r.rd;
		imm_o             = imm.imm_i;
		alusrc_a_o        = ALUSRCA_RS1;
		alusrc_b_o        = ALUSRCB_RS2;
		aluop_o           = ALUOP_ADD;
		memop_o           = MEMOP_NONE;
		mulop_o           = M_OP_MUL;
		csr_ren_o         = 1'b0;
		csr_wen_o         = 1'b0;
		csr_wtype_o       = CSR_WTYPE_W;
		csr_w_imm_o       = 1'b0;
		branchcond_o      = BCOND_NEVER;
		jump_is_regoffs_o = 1'b0;
		except_o          = EXCEPT_NONE;
		wfi_o             = 1'b0;
		invalid           = 1'b0;

		case (opcode)
			OPC_LUI, OPC_AUIPC: begin
				imm_o      = imm.imm_u;
				alusrc_b_o = ALUSRCB_IMM;
				rs1_o      = X0;
				rs2_o      = X0;
				if (opcode == OPC_AUIPC)
					alusrc_a_o = ALUSRCA_PC;
			end
			// Both jumps compute the link address PC + 4 in the ALU
			OPC_JAL, OPC_JALR: begin
				branchcond_o = BCOND_ALWAYS;
				rs2_o        = X0;
				alusrc_a_o   = ALUSRCA_PC;
				alusrc_b_o   = ALUSRCB_IMM;
				imm_o        = LINK_STEP;
				if (opcode == OPC_JAL) begin
					rs1_o = X0;
				end else begin
					jump_is_regoffs_o = 1'b1;
					invalid           = funct3 != 3'b000;
				end
			end
			OPC_BRANCH: begin
				rd_o  = X0;
				imm_o = imm.imm_b;
				case (funct3[2:1])
					2'b00:   aluop_o = ALUOP_SUB;
					2'b10:   aluop_o = ALUOP_LT;
					2'b11:   aluop_o = ALUOP_LTU;
					default: invalid = 1'b1;
				endcase
				// BNE, BLT and BLTU take the branch on a non-zero result
				branchcond_o = (funct3[2] ^ funct3[0]) ? BCOND_NZERO : BCOND_ZERO;
			end
			OPC_LOAD: begin
				alusrc_b_o = ALUSRCB_IMM;
				rs2_o      = X0;
				case (funct3)
					3'b000:  memop_o = MEMOP_LB;
					3'b001:  memop_o = MEMOP_LH;
					3'b010:  memop_o = MEMOP_LW;
					3'b100:  memop_o = MEMOP_LBU;
					3'b101:  memop_o = MEMOP_LHU;
					default: invalid = 1'b1;
				endcase
			end
			OPC_STORE: begin
				imm_o      = imm.imm_s;
				alusrc_b_o = ALUSRCB_IMM;
				rd_o       = X0;
				case (funct3)
					3'b000:  memop_o = MEMOP_SB;
					3'b001:  memop_o = MEMOP_SH;
					3'b010:  memop_o = MEMOP_SW;
					default: invalid = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				alusrc_b_o = ALUSRCB_IMM;
				rs2_o      = X0;
				aluop_o    = f3_aluop(funct3, funct3 == 3'b101 && funct7[5]);
				// Shift amounts only use the low five immediate bits
				if (funct3 == 3'b001)
					invalid = !f7_zero;
				else if (funct3 == 3'b101)
					invalid = !(f7_zero || f7_alt);
			end
			OPC_OP: begin
				if (funct7 == 7'b0000001) begin
					if (`RV_HAVE_M) begin
						aluop_o = ALUOP_MULDIV;
						mulop_o = mulop_e'(funct3);
					end else begin
						invalid = 1'b1;
					end
				end else begin
					aluop_o = f3_aluop(funct3, funct7[5]);
					invalid = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
				end
			end
			// FENCE and FENCE.I have nothing to order here
			OPC_MISC_MEM: begin
				rd_o    = X0;
				invalid = funct3[2:1] != 2'b00;
			end
			OPC_SYSTEM: begin
				if (!`RV_HAVE_CSR) begin
					invalid = 1'b1;
				end else if (funct3 == 3'b000) begin
					rs1_o = X0;
					rs2_o = X0;
					rd_o  = X0;
					case (instr_i)
						32'h0000_0073: except_o = EXCEPT_ECALL;
						32'h0010_0073: except_o = EXCEPT_EBREAK;
						32'h3020_0073: except_o = EXCEPT_MRET;
						32'h1050_0073: wfi_o = 1'b1;
						default:       invalid = 1'b1;
					endcase
				end else begin
					// Set and clear with x0 (or zero uimm) only read the CSR
					csr_w_imm_o = funct3[2];
					csr_ren_o   = 1'b1;
					csr_wen_o   = |instr_i.r.rs1;
					case (funct3[1:0])
						2'b01: begin
							csr_wtype_o = CSR_WTYPE_W;
							csr_wen_o   = 1'b1;
							csr_ren_o   = |instr_i.r.rd;
						end
						2'b10:   csr_wtype_o = CSR_WTYPE_S;
						2'b11:   csr_wtype_o = CSR_WTYPE_C;
						default: invalid = 1'b1;
					endcase
				end
			end
			default: invalid = 1'b1;
		endcase

		// A squashed word must have no side effect besides its exception
		if (invalid || starved_i || bus_fault_i) begin
			rs1_o        = X0;
			rs2_o        = X0;
			rd_o         = X0;
			memop_o      = MEMOP_NONE;
			branchcond_o = BCOND_NEVER;
			csr_ren_o    = 1'b0;
			csr_wen_o    = 1'b0;
			wfi_o        = 1'b0;
			aluop_o      = ALUOP_ADD;
			except_o     = EXCEPT_NONE;
			if (bus_fault_i)
				except_o = EXCEPT_INSTR_FAULT;
			else if (invalid && !starved_i)
				except_o = EXCEPT_INSTR_ILLEGAL;
		end

		// The jump of a locked word was already taken
		if (lock_prev_i)
			branchcond_o = BCOND_NEVER;

		a_fault_no_memop: assert (except_o != EXCEPT_INSTR_FAULT || memop_o == MEMOP_NONE);
	end

endmodule

//--- hw/rv_decode_stage.sv
// ----------------------------------------
// Decode stage top level
// Immediate generator, PC/CIR control and the
// instruction decoder behind plain ports
// ----------------------------------------

`include "rv_decode_macros.svh"

module rv_decode_stage (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [`RV_XLEN-1:0]         cir_i,
	input  logic                        cir_vld_i,
	input  logic                        cir_err_i,
	input  logic                        x_stall_i,
	input  logic                        jump_now_i,
	input  logic [`RV_XLEN-1:0]         jump_target_i,
	input  logic                        jump_not_except_i,
	output logic                        cir_use_o,
	output logic                        cir_lock_o,
	output logic                        starved_o,
	output logic [`RV_XLEN-1:0]         pc_o,
	output logic [`RV_XLEN-1:0]         imm_o,
	output logic [`RV_REGADDR_W-1:0]    rs1_o,
	output logic [`RV_REGADDR_W-1:0]    rs2_o,
	output logic [`RV_REGADDR_W-1:0]    rd_o,
	output rv_decode_pkg::alusrc_a_e    alusrc_a_o,
	output rv_decode_pkg::alusrc_b_e    alusrc_b_o,
	output rv_decode_pkg::aluop_e       aluop_o,
	output rv_decode_pkg::memop_e       memop_o,
	output rv_decode_pkg::mulop_e       mulop_o,
	output logic                        csr_ren_o,
	output logic                        csr_wen_o,
	output rv_decode_pkg::csr_wtype_e   csr_wtype_o,
	output logic                        csr_w_imm_o,
	output rv_decode_pkg::bcond_e       branchcond_o,
	output logic [`RV_XLEN-1:0]         jump_offs_o,
	output logic                        jump_is_regoffs_o,
	output rv_decode_pkg::except_e      except_o,
	output logic                        wfi_o
);
	import rv_decode_pkg::*;

	instr_u cir_word;
	logic   bus_fault;
	logic   lock_prev;

	rv_imm_if imm_bus ();

	assign cir_word = cir_i;

	rv_imm_gen imm_gen_inst (
		.instr_i     (cir_word),
		.imm         (imm_bus.producer),
		.jump_offs_o (jump_offs_o)
	);

	rv_pc_ctrl pc_ctrl_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.cir_vld_i         (cir_vld_i),
		.cir_err_i         (cir_err_i),
		.x_stall_i         (x_stall_i),
		.jump_now_i        (jump_now_i),
		.jump_target_i     (jump_target_i),
		.jump_not_except_i (jump_not_except_i),
		.cir_use_o         (cir_use_o),
		.cir_lock_o        (cir_lock_o),
		.starved_o         (starved_o),
		.bus_fault_o       (bus_fault),
		.lock_prev_o       (lock_prev),
		.pc_o              (pc_o)
	);

	rv_instr_decoder decoder_inst (
		.instr_i           (cir_word),
		.imm               (imm_bus.consumer),
		.starved_i         (starved_o),
		.bus_fault_i       (bus_fault),
		.lock_prev_i       (lock_prev),
		.imm_o             (imm_o),
		.rs1_o             (rs1_o),
		.rs2_o             (rs2_o),
		.rd_o              (rd_o),
		.alusrc_a_o        (alusrc_a_o),
		.alusrc_b_o        (alusrc_b_o),
		.aluop_o           (aluop_o),
		.memop_o           (memop_o),
		.mulop_o           (mulop_o),
		.csr_ren_o         (csr_ren_o),
		.csr_wen_o         (csr_wen_o),
		.csr_wtype_o       (csr_wtype_o),
		.csr_w_imm_o       (csr_w_imm_o),
		.branchcond_o      (branchcond_o),
		.jump_is_regoffs_o (jump_is_regoffs_o),
		.except_o          (except_o),
		.wfi_o             (wfi_o)
	);

endmodule

//--- test/tb_rv_decode_vectors.svh
// ----------------------------------------
// Stimulus and expected values for the
// decode stage testbench, one row per cycle
// ----------------------------------------

// Row: word, vld, err, stall, jump_now, jump_not_except, target (0 picks a random one)
//      aluop, memop, mulop, branchcond, except, rs1, rs2, rd, imm
//      alusrc_b, csr_ren, csr_wen, regoffs, jump_offs (0 skips it), use, lock
//      alusrc_a, csr_wtype, csr_w_imm, wfi
task automatic load_vectors();
	// Base integer, load, store and upper immediate
	add_row(32'h0051_0093, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 2, 0, 1, 32'h5, ALUSRCB_IMM, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h0082_2183, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_LW, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 4, 0, 3, 32'h8, ALUSRCB_IMM, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h0053_2623, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_SW, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 6, 5, 0, 32'hC, ALUSRCB_IMM, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h1234_53B7, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 0, 0, 7, 32'h1234_5000, ALUSRCB_IMM, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	// Branches and jumps
	add_row(32'h0020_8863, 1, 0, 0, 0, 0, 0, ALUOP_SUB, MEMOP_NONE, M_OP_MUL, BCOND_ZERO,
		EXCEPT_NONE, 1, 2, 0, 32'h10, ALUSRCB_RS2, 0, 0, 0, 32'h10, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'hFE41_CCE3, 1, 0, 0, 0, 0, 0, ALUOP_LT, MEMOP_NONE, M_OP_MUL, BCOND_NZERO,
		EXCEPT_NONE, 3, 4, 0, 32'hFFFF_FFF8, ALUSRCB_RS2, 0, 0, 0, 32'hFFFF_FFF8, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h0010_00EF, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_ALWAYS,
		EXCEPT_NONE, 0, 0, 1, 32'h4, ALUSRCB_IMM, 0, 0, 0, 32'h800, 1, 0,
		ALUSRCA_PC, CSR_WTYPE_W, 0, 0);
	add_row(32'hFFC2_80E7, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_ALWAYS,
		EXCEPT_NONE, 5, 0, 1, 32'h4, ALUSRCB_IMM, 0, 0, 1, 32'hFFFF_FFFC, 1, 0,
		ALUSRCA_PC, CSR_WTYPE_W, 0, 0);
	// M extension, CSR and system
	add_row(32'h02C5_8533, 1, 0, 0, 0, 0, 0, ALUOP_MULDIV, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 11, 12, 10, 32'h2C, ALUSRCB_RS2, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h02C5_D533, 1, 0, 0, 0, 0, 0, ALUOP_MULDIV, MEMOP_NONE, M_OP_DIVU, BCOND_NEVER,
		EXCEPT_NONE, 11, 12, 10, 32'h2C, ALUSRCB_RS2, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h3000_22F3, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 0, 0, 5, 32'h300, ALUSRCB_RS2, 1, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_S, 0, 0);
	// CSRRCI with a non-zero uimm writes the CSR
	add_row(32'h3004_7073, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 8, 0, 0, 32'h300, ALUSRCB_RS2, 1, 1, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_C, 1, 0);
	add_row(32'h0000_0073, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_ECALL, 0, 0, 0, 32'h0, ALUSRCB_RS2, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h1050_0073, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 0, 0, 0, 32'h105, ALUSRCB_RS2, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 1);
	// Squashed words: illegal, bus fault, starved
	add_row(32'h0000_0000, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_INSTR_ILLEGAL, 0, 0, 0, 32'h0, ALUSRCB_RS2, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h0082_2183, 1, 1, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_INSTR_FAULT, 0, 0, 0, 32'h8, ALUSRCB_IMM, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h0051_0093, 0, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 0, 0, 0, 32'h5, ALUSRCB_IMM, 0, 0, 0, 0, 0, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	// Stall holds the PC, then a jump with and without a stall behind it
	add_row(32'h0051_0093, 1, 0, 1, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 2, 0, 1, 32'h5, ALUSRCB_IMM, 0, 0, 0, 0, 0, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h0010_00EF, 1, 0, 0, 1, 1, 32'h100, ALUOP_ADD, MEMOP_NONE, M_OP_MUL,
		BCOND_ALWAYS, EXCEPT_NONE, 0, 0, 1, 32'h4, ALUSRCB_IMM, 0, 0, 0, 32'h800, 1, 0,
		ALUSRCA_PC, CSR_WTYPE_W, 0, 0);
	add_row(32'h0051_0093, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 2, 0, 1, 32'h5, ALUSRCB_IMM, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h0010_00EF, 1, 0, 1, 1, 1, 32'h200, ALUOP_ADD, MEMOP_NONE, M_OP_MUL,
		BCOND_ALWAYS, EXCEPT_NONE, 0, 0, 1, 32'h4, ALUSRCB_IMM, 0, 0, 0, 32'h800, 0, 1,
		ALUSRCA_PC, CSR_WTYPE_W, 0, 0);
	add_row(32'h0010_00EF, 1, 0, 1, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_ALWAYS,
		EXCEPT_NONE, 0, 0, 1, 32'h4, ALUSRCB_IMM, 0, 0, 0, 32'h800, 0, 1,
		ALUSRCA_PC, CSR_WTYPE_W, 0, 0);
	add_row(32'h0010_00EF, 1, 0, 0, 0, 0, 32'h300, ALUOP_ADD, MEMOP_NONE, M_OP_MUL,
		BCOND_ALWAYS, EXCEPT_NONE, 0, 0, 1, 32'h4, ALUSRCB_IMM, 0, 0, 0, 32'h800, 1, 0,
		ALUSRCA_PC, CSR_WTYPE_W, 0, 0);
	add_row(32'h0051_0093, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 2, 0, 1, 32'h5, ALUSRCB_IMM, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
	add_row(32'h0051_0093, 1, 0, 0, 0, 0, 0, ALUOP_ADD, MEMOP_NONE, M_OP_MUL, BCOND_NEVER,
		EXCEPT_NONE, 2, 0, 1, 32'h5, ALUSRCB_IMM, 0, 0, 0, 0, 1, 0,
		ALUSRCA_RS1, CSR_WTYPE_W, 0, 0);
endtask

//--- test/tb_rv_decode_stage.sv
// ----------------------------------------
// Decode stage testbench
// Clock, reset, table driven stimulus, typed
// compare tasks, a PC/lock model and a timeout
// ----------------------------------------

`include "rv_decode_macros.svh"

module tb_rv_decode_stage;
	import rv_decode_pkg::*;

	typedef struct {
		logic [31:0] instr;
		logic        vld, err, stall, jnow, jne;
		logic [31:0] tgt;
		aluop_e      aluop;
		memop_e      memop;
		mulop_e      mulop;
		bcond_e      bcond;
		except_e     exc;
		logic [4:0]  rs1, rs2, rd;
		logic [31:0] imm;
		alusrc_b_e   srcb;
		logic        ren, wen, regoffs;
		logic [31:0] joffs;
		logic        use_exp, lock_exp;
		alusrc_a_e   srca;
		csr_wtype_e  wtype;
		logic        wimm, wfi;
	} row_t;

	logic clk, rst_n;
	logic [31:0] cir_i, jump_target_i;
	logic cir_vld_i, cir_err_i, x_stall_i, jump_now_i, jump_not_except_i;
	logic cir_use_o, cir_lock_o, starved_o;
	logic [31:0] pc_o, imm_o, jump_offs_o;
	logic [4:0] rs1_o, rs2_o, rd_o;
	alusrc_a_e alusrc_a_o;
	alusrc_b_e alusrc_b_o;
	aluop_e aluop_o;
	memop_e memop_o;
	mulop_e mulop_o;
	logic csr_ren_o, csr_wen_o, csr_w_imm_o, jump_is_regoffs_o, wfi_o;
	csr_wtype_e csr_wtype_o;
	bcond_e branchcond_o;
	except_e except_o;

	row_t vec[$];
	int cycles = 0;
	int limit = 0;
	logic [31:0] model_pc;
	logic model_lock_prev;

	rv_decode_stage rv_decode_stage_inst (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// The limit is only armed once the table is loaded
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("The run did not finish within %0d cycles", limit);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	task automatic add_row(input logic [31:0] instr, input logic vld, err, stall, jnow, jne,
		input logic [31:0] tgt, input aluop_e aluop, input memop_e memop, input mulop_e mulop,
		input bcond_e bcond, input except_e exc, input logic [4:0] rs1, rs2, rd,
		input logic [31:0] imm, input alusrc_b_e srcb, input logic ren, wen, regoffs,
		input logic [31:0] joffs, input logic use_exp, lock_exp,
		input alusrc_a_e srca, input csr_wtype_e wtype, input logic wimm, wfi);
		row_t r;
		r = '{instr, vld, err, stall, jnow, jne, tgt, aluop, memop, mulop, bcond, exc,
			rs1, rs2, rd, imm, srcb, ren, wen, regoffs, joffs, use_exp, lock_exp,
			srca, wtype, wimm, wfi};
		vec.push_back(r);
	endtask

	`include "tb_rv_decode_vectors.svh"

	// ----------------------------------------
	// Compare tasks

	task automatic report_mismatch(input string name, input logic [31:0] exp, act);
		$display("Fail %s expected %h actual %h", name, exp, act);
		$display("Test failed");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic check_aluop(input string name, input aluop_e exp, act);
		if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
	endtask

	task automatic check_memop(input string name, input memop_e exp, act);
		if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
	endtask

	task automatic check_mulop(input string name, input mulop_e exp, act);
		if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
	endtask

	task automatic check_bcond(input string name, input bcond_e exp, act);
		if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
	endtask

	task automatic check_except(input string name, input except_e exp, act);
		if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
	endtask

	task automatic check_srca(input string name, input alusrc_a_e exp, act);
		if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
	endtask

	task automatic check_srcb(input string name, input alusrc_b_e exp, act);
		if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
	endtask

	task automatic check_wtype(input string name, input csr_wtype_e exp, act);
		if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
	endtask

	task automatic check_reg(input string name, input logic [4:0] exp, act);
		if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, act);
		if (act !== exp) report_mismatch(name, exp, act);
	endtask

	task automatic check_bit(input string name, input logic exp, act);
		if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
	endtask

	// ----------------------------------------
	// Stimulus loop

	initial begin
		row_t r;
		logic [31:0] tgt;
		logic d_stall, new_lock, lock, jump_load;
		bcond_e exp_bcond;

		void'($urandom(32'h4952_5658));
		rst_n = 1'b0;
		cir_i = '0;
		cir_vld_i = 1'b0;
		cir_err_i = 1'b0;
		x_stall_i = 1'b0;
		jump_now_i = 1'b0;
		jump_not_except_i = 1'b0;
		jump_target_i = '0;
		load_vectors();
		limit = vec.size() + 5 + 10;
		model_pc = `RV_RESET_VECTOR;
		model_lock_prev = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		foreach (vec[i]) begin
			r = vec[i];
			tgt = (r.tgt != 0) ? r.tgt : $urandom;
			@(posedge clk);
			cir_i <= r.instr;
			cir_vld_i <= r.vld;
			cir_err_i <= r.err;
			x_stall_i <= r.stall;
			jump_now_i <= r.jnow;
			jump_not_except_i <= r.jne;
			jump_target_i <= tgt;
			@(negedge clk);

			// Reference lock rule, the jump of a locked word is already gone
			d_stall = r.stall || !r.vld;
			new_lock = r.jnow && r.jne && d_stall;
			lock = (model_lock_prev && d_stall) || new_lock;
			exp_bcond = model_lock_prev ? BCOND_NEVER : r.bcond;

			check_aluop("aluop_o", r.aluop, aluop_o);
			check_memop("memop_o", r.memop, memop_o);
			check_mulop("mulop_o", r.mulop, mulop_o);
			check_bcond("branchcond_o", exp_bcond, branchcond_o);
			check_except("except_o", r.exc, except_o);
			check_srca("alusrc_a_o", r.srca, alusrc_a_o);
			check_srcb("alusrc_b_o", r.srcb, alusrc_b_o);
			check_reg("rs1_o", r.rs1, rs1_o);
			check_reg("rs2_o", r.rs2, rs2_o);
			check_reg("rd_o", r.rd, rd_o);
			check_word("imm_o", r.imm, imm_o);
			if (r.joffs != 0)
				check_word("jump_offs_o", r.joffs, jump_offs_o);
			check_bit("jump_is_regoffs_o", r.regoffs, jump_is_regoffs_o);
			check_bit("csr_ren_o", r.ren, csr_ren_o);
			check_bit("csr_wen_o", r.wen, csr_wen_o);
			check_wtype("csr_wtype_o", r.wtype, csr_wtype_o);
			check_bit("csr_w_imm_o", r.wimm, csr_w_imm_o);
			check_bit("wfi_o", r.wfi, wfi_o);
			check_bit("starved_o", !r.vld, starved_o);
			check_bit("cir_use_o", r.use_exp, cir_use_o);
			check_bit("cir_lock_o", r.lock_exp, cir_lock_o);
			check_word("pc_o", model_pc, pc_o);

			// Next PC as seen at the coming edge
			jump_load = (r.jnow && !new_lock) || (model_lock_prev && !d_stall);
			if (jump_load)
				model_pc = tgt;
			else if (!d_stall && !lock)
				model_pc = model_pc + `RV_INSTR_STEP;
			model_lock_prev = lock;
		end

		$display("Test passed");
		$finish;
	end

endmodule

//--- all.f
+incdir+include
+incdir+test
hw/rv_decode_pkg.sv
hw/rv_imm_if.sv
hw/rv_imm_gen.sv
hw/rv_pc_ctrl.sv
hw/rv_instr_decoder.sv
hw/rv_decode_stage.sv
test/tb_rv_decode_stage.sv

//--- Makefile
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_decode_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
